// ==== all.f ====
rtl/uart_pkg.sv
rtl/char_if.sv
rtl/serial_rx.sv
rtl/rx_fifo.sv
rtl/uart_regs.sv
rtl/serial_tx.sv
rtl/uart_top.sv
tests/uart_checker.sv
tests/uart_tb.sv

// ==== tests/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
  import uart_pkg::*;

  localparam int cpb   = 16;
  localparam int depth = 4;

  typedef enum {k_send, k_bad_stop, k_glitch, k_lost_start, k_burst, k_xmit} kind_t;

  typedef struct {
    string    name;
    kind_t    kind;
    logic [7:0] data;
    rx_word_t exp_word;   // tx byte sits in .data for k_xmit
  } row_t;

  logic       clk100 = 1'b0;
  logic       reset;
  logic       cyc;
  logic       stb;
  logic       we;
  logic       adr;
  logic [9:0] dat_w;
  logic [9:0] dat_r;
  logic       ack;
  logic       rx;
  logic       tx;
  row_t       rows[$];
  int         seed;
  int         cycles = 0;
  int         limit = 1000000;

  uart_top #(.clks_per_bit(cpb), .fifo_depth(depth)) dut0 (
    .clk100(clk100), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .rx(rx), .tx(tx)
  );

  always #10 clk100 = ~clk100;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopping simulation");
  endtask

  always @(posedge clk100) begin
    cycles <= cycles + 1;
    if (cycles > limit) stop_with_failure($sformatf("timeout after %0d cycles", cycles));
  end

  task automatic check_word(input string name, input rx_word_t exp, input rx_word_t got);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, got));
    end
  endtask

  task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] got);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s: expected %b, actual %b", name, exp, got));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      stop_with_failure($sformatf("error %s: expected %h, actual %h", name, exp, got));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk100);
      #2;
    end
  endtask

  // one classic cycle, then one idle cycle
  task automatic wb_cycle(input reg_addr_t a, input logic is_write, input logic [9:0] wdata,
                          output logic [9:0] rdata, output int waited);
    waited = 0;
    cyc = 1'b1;
    stb = 1'b1;
    we = is_write;
    adr = a;
    dat_w = wdata;
    do begin
      wait_cycles(1);
      waited++;
    end while (!ack);
    rdata = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    wait_cycles(1);
  endtask

  task automatic read_status(output logic [2:0] st);
    logic [9:0] d;
    int w;
    wb_cycle(reg_status, 1'b0, '0, d, w);
    st = d[2:0];
  endtask

  task automatic read_word(output rx_word_t word);
    logic [9:0] d;
    int w;
    wb_cycle(reg_data, 1'b0, '0, d, w);
    word = rx_word_t'(d);
  endtask

  task automatic write_reg(input reg_addr_t a, input logic [7:0] b, output int waited);
    logic [9:0] d;
    wb_cycle(a, 1'b1, {2'b00, b}, d, waited);
  endtask

  task automatic wait_status_bit(input int idx);
    logic [2:0] st;
    do read_status(st); while (!st[idx]);
  endtask

  // lsb first and one idle bit after the stop bit
  task automatic send_frame(input logic [7:0] b, input logic stop);
    int i;
    rx = 1'b0;
    wait_cycles(cpb);
    for (i = 0; i < 8; i++) begin
      rx = b[i];
      wait_cycles(cpb);
    end
    rx = stop;
    wait_cycles(cpb);
    rx = 1'b1;
    wait_cycles(cpb);
  endtask

  task automatic capture_byte(input string name, output logic [7:0] b);
    int i;
    while (tx !== 1'b0) wait_cycles(1);
    wait_cycles(cpb / 2);       // middle of start bit
    if (tx !== 1'b0) stop_with_failure({name, ": tx start bit is not low at its middle"});
    for (i = 0; i < 8; i++) begin
      wait_cycles(cpb);
      b[i] = tx;
    end
    wait_cycles(cpb);
    if (tx !== 1'b1) stop_with_failure({name, ": tx stop bit is not high"});
  endtask

  task automatic receive_and_check(input string name, input rx_word_t exp);
    rx_word_t   w;
    logic [2:0] st;
    wait_status_bit(0);
    read_word(w);
    check_word(name, exp, w);
    read_status(st);
    check_status(name, 3'b000, st);
  endtask

  task automatic add_row(input string name, input kind_t k, input logic [7:0] d,
                         input rx_word_t e);
    row_t r;
    r.name = name;
    r.kind = k;
    r.data = d;
    r.exp_word = e;
    rows.push_back(r);
  endtask

  task automatic run_row(input row_t r);
    logic [2:0] st;
    rx_word_t   w;
    rx_word_t   e;
    logic [7:0] g0;
    logic [7:0] g1;
    int         w0;
    int         w1;
    int         i;
    case (r.kind)
      k_send: begin
        send_frame(r.data, 1'b1);
        receive_and_check(r.name, r.exp_word);
      end
      k_bad_stop: begin
        send_frame(r.data, 1'b0);
        receive_and_check(r.name, r.exp_word);
      end
      k_glitch: begin
        rx = 1'b0;
        wait_cycles(cpb / 4 - 2);
        rx = 1'b1;
        wait_cycles(2 * cpb);
        read_status(st);
        check_status(r.name, 3'b000, st);
      end
      k_lost_start: begin
        rx = 1'b0;
        wait_cycles(cpb / 4 + 2);   // past the check and high by mid start
        rx = 1'b1;
        wait_cycles(cpb);
        receive_and_check(r.name, r.exp_word);
      end
      k_burst: begin
        for (i = 0; i <= depth; i++) send_frame(r.data + 8'(i), 1'b1);
        wait_status_bit(1);
        read_status(st);
        check_status(r.name, 3'b011, st);
        for (i = 0; i < depth; i++) begin
          e = r.exp_word;
          e.data = r.exp_word.data + 8'(i);
          read_word(w);
          check_word(r.name, e, w);
        end
        write_reg(reg_status, 8'h00, w0);
        read_status(st);
        check_status(r.name, 3'b000, st);
      end
      k_xmit: begin
        fork
          begin
            write_reg(reg_data, r.data, w0);
            read_status(st);
            check_status(r.name, 3'b100, st); // first byte still on the line
            write_reg(reg_data, ~r.data, w1);
          end
          begin
            capture_byte(r.name, g0);
            capture_byte(r.name, g1);
          end
        join
        check_byte(r.name, r.exp_word.data, g0);
        check_byte(r.name, ~r.exp_word.data, g1);
        if (w1 < 9 * cpb) stop_with_failure({r.name, ": second write acked while tx was busy"});
      end
      default: stop_with_failure({r.name, ": unknown row kind"});
    endcase
  endtask

  initial begin
    logic [7:0] b;
    logic [2:0] st;
    int         n;
    reset = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = 1'b0;
    dat_w = '0;
    rx = 1'b1;
    seed = 32'h1e450131;
    add_row("send_55", k_send, 8'h55, {2'b00, 8'h55});
    add_row("send_a3", k_send, 8'ha3, {2'b00, 8'ha3});
    b = 8'($random(seed));
    add_row("send_rand0", k_send, b, {2'b00, b});
    b = 8'($random(seed));
    add_row("send_rand1", k_send, b, {2'b00, b});
    add_row("bad_stop", k_bad_stop, 8'h3c, {2'b01, 8'h3c});
    add_row("glitch", k_glitch, 8'h00, '0);
    add_row("lost_start", k_lost_start, 8'h00, {2'b10, 8'h00});
    b = 8'($random(seed));
    add_row("overflow", k_burst, b, {2'b00, b});
    add_row("transmit", k_xmit, 8'hc5, {2'b00, 8'hc5});
    limit = rows.size() * 12 * 10 * cpb + 2000; // 12 frames per row
    repeat (3) @(posedge clk100);
    #2;
    reset = 1'b0;
    wait_cycles(1);
    if (tx !== 1'b1) stop_with_failure("tx is not high after reset");
    read_status(st);
    check_status("after_reset", 3'b000, st);
    for (n = 0; n < rows.size(); n++) run_row(rows[n]);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/uart_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
  input wire logic          clk100,
  input wire logic          reset,
  input wire logic          cyc,
  input wire logic          stb,
  input wire logic          ack,
  input wire logic          tx,
  input wire logic          rx_valid,
  input var uart_pkg::tx_state_t tx_state
);
  import uart_pkg::*;

  ack_one_cycle: assert property (@(posedge clk100) disable iff (reset) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  ack_after_request: assert property (@(posedge clk100) disable iff (reset)
    $rose(ack) |-> $past(cyc && stb))
    else $error("ack rose without a cyc and stb request");

  // line must idle high
  tx_high_when_idle: assert property (@(posedge clk100) disable iff (reset)
    (tx_state == tx_idle) |-> tx)
    else $error("tx low while the transmitter is idle");

  rx_valid_pulse: assert property (@(posedge clk100) disable iff (reset)
    rx_valid |=> !rx_valid)
    else $error("receiver valid high two cycles in a row");

endmodule

bind uart_top uart_checker chk0 (
  .clk100   (clk100),
  .reset    (reset),
  .cyc      (cyc),
  .stb      (stb),
  .ack      (ack),
  .tx       (tx),
  .rx_valid (rx_stream.valid),
  .tx_state (u_tx.state)
);

`default_nettype wire

// ==== rtl/uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
  parameter int clks_per_bit = 868, // 115200 baud at 100 MHz
  parameter int fifo_depth   = 4
) (
  input  wire logic       clk100,
  input  wire logic       reset,
  input  wire logic       cyc,
  input  wire logic       stb,
  input  wire logic       we,
  input  wire logic       adr,
  input  wire logic [9:0] dat_w,
  output logic      [9:0] dat_r,
  output logic            ack,
  input  wire logic       rx,
  output logic            tx
);

  logic overflow;
  logic clear_overflow;
  logic tx_busy;

  char_if rx_stream ();  // receiver to fifo
  char_if fifo_out ();   // fifo to registers
  char_if tx_stream ();  // registers to transmitter

  serial_rx #(
    .clks_per_bit(clks_per_bit)
  ) u_rx (
    .clk100 (clk100),
    .reset  (reset),
    .rx     (rx),
    .out    (rx_stream.source)
  );

  rx_fifo #(
    .fifo_depth(fifo_depth)
  ) u_fifo (
    .clk100         (clk100),
    .reset          (reset),
    .in             (rx_stream.sink),
    .out            (fifo_out.source),
    .overflow       (overflow),
    .clear_overflow (clear_overflow)
  );

  uart_regs u_regs (
    .clk100         (clk100),
    .reset          (reset),
    .cyc            (cyc),
    .stb            (stb),
    .we             (we),
    .adr            (adr),
    .dat_w          (dat_w),
    .dat_r          (dat_r),
    .ack            (ack),
    .rx_in          (fifo_out.sink),
    .overflow       (overflow),
    .clear_overflow (clear_overflow),
    .tx_out         (tx_stream.source),
    .tx_busy        (tx_busy)
  );

  serial_tx #(
    .clks_per_bit(clks_per_bit)
  ) u_tx (
    .clk100 (clk100),
    .reset  (reset),
    .in     (tx_stream.sink),
    .tx     (tx),
    .busy   (tx_busy)
  );

endmodule

`default_nettype wire

// ==== rtl/serial_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_tx #(
  parameter int clks_per_bit = 868
) (
  input  wire logic clk100,
  input  wire logic reset,
  char_if.sink      in,
  output logic      tx,
  output logic      busy
);
  import uart_pkg::*;

  localparam int tw = $clog2(clks_per_bit);

  tx_state_t     state;
  logic [tw-1:0] timer;
  logic [2:0]    bit_cnt;
  logic [7:0]    shift;

  assign in.ready = (state == tx_idle);
  assign busy     = (state != tx_idle);

  always_ff @(posedge clk100) begin
    if (reset) begin
      state   <= tx_idle;
      timer   <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;  // line idles high
    end else begin
      case (state)
        tx_idle: begin
          if (in.valid) begin
            tx    <= 1'b0; // start bit from next cycle
            timer <= tw'(clks_per_bit - 1);
            state <= tx_start;
          end
        end
        tx_start: begin
          if (timer == '0) begin
            tx      <= shift[0];
            timer   <= tw'(clks_per_bit - 1);
            bit_cnt <= '0;
            state   <= tx_data;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        tx_data: begin
          if (timer == '0) begin
            timer <= tw'(clks_per_bit - 1);
            if (bit_cnt == 3'd7) begin
              tx    <= 1'b1;   // stop bit
              state <= tx_stop;
            end else begin
              tx      <= shift[1];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            timer <= timer - 1'b1;
          end
        end
        tx_stop: begin
          if (timer == '0) state <= tx_idle;
          else timer <= timer - 1'b1;
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // shifter keeps the current bit at position 0
  always_ff @(posedge clk100) begin
    if (state == tx_idle && in.valid) begin
      shift <= in.word.data;
    end else if (state == tx_data && timer == '0) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
  input  wire logic       clk100,
  input  wire logic       reset,
  input  wire logic       cyc,
  input  wire logic       stb,
  input  wire logic       we,
  input  wire logic       adr,
  input  wire logic [9:0] dat_w,
  output logic      [9:0] dat_r,
  output logic            ack,
  char_if.sink            rx_in,
  input  wire logic       overflow,
  output logic            clear_overflow,
  char_if.source          tx_out,
  input  wire logic       tx_busy
);
  import uart_pkg::*;

  reg_addr_t addr;
  logic      req;
  logic      rd_data;
  logic      wr_data;
  logic      rd_status;
  logic      wr_status;
  logic      ack_next;

  assign addr = reg_addr_t'(adr);
  assign req  = cyc && stb && !ack;   // open request, not yet acked

  always_comb begin
    rd_data   = 1'b0;
    wr_data   = 1'b0;
    rd_status = 1'b0;
    wr_status = 1'b0;
    case (addr)
      reg_data: begin
        rd_data = req && !we;
        wr_data = req && we;
      end
      reg_status: begin
        rd_status = req && !we;
        wr_status = req && we;
      end
      default: ;
    endcase
  end

  // data read pops the fifo head
  assign rx_in.ready    = rd_data;
  assign clear_overflow = wr_status; // any value clears

  // held until serial_tx takes it
  assign tx_out.valid          = wr_data;
  assign tx_out.word.start_err = 1'b0;
  assign tx_out.word.frame_err = 1'b0;
  assign tx_out.word.data      = dat_w[7:0];

  // data writes wait for the transmitter, everything else acks next cycle
  assign ack_next = rd_data || rd_status || wr_status || (tx_out.valid && tx_out.ready);

  always_ff @(posedge clk100) begin
    if (reset) ack <= 1'b0;
    else ack <= ack_next;
  end

  always_ff @(posedge clk100) begin
    if (rd_data) begin
      dat_r <= rx_in.valid ? rx_in.word : '0; // empty reads as zero
    end else if (rd_status) begin
      dat_r <= {7'd0, tx_busy, overflow, rx_in.valid};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fifo #(
  parameter int fifo_depth = 4
) (
  input  wire logic clk100,
  input  wire logic reset,
  char_if.sink      in,
  char_if.source    out,
  output logic      overflow,
  input  wire logic clear_overflow
);
  import uart_pkg::*;

  localparam int aw = $clog2(fifo_depth);

  rx_word_t      mem [fifo_depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic          full;
  logic          push;
  logic          pop;

  assign full = (count == (aw + 1)'(fifo_depth));
  assign push = in.valid && !full;
  assign pop  = out.valid && out.ready;

  assign in.ready  = 1'b1;            // never stalls the receiver
  assign out.valid = (count != '0);
  assign out.word  = mem[rd_ptr];

  always_ff @(posedge clk100) begin
    if (push) mem[wr_ptr] <= in.word;
  end

  always_ff @(posedge clk100) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
      if (in.valid && full) overflow <= 1'b1; // word dropped
      else if (clear_overflow) overflow <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/serial_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_rx #(
  parameter int clks_per_bit = 868
) (
  input  wire logic clk100,
  input  wire logic reset,
  input  wire logic rx,
  char_if.source    out
);
  import uart_pkg::*;

  localparam int tw      = $clog2(clks_per_bit);
  localparam int quarter = clks_per_bit / 4;
  localparam int to_mid  = clks_per_bit / 2 - quarter - 1; // rest of the way to mid start

  rx_state_t     state;
  logic [tw-1:0] timer;
  logic [2:0]    bit_cnt;
  logic          rx_meta;
  logic          rx_sync;
  logic          rx_prev;   // for falling edge detect
  logic [7:0]    shift;
  rx_word_t      word_q;

  // two flops ahead of any use, third one for the edge
  always_ff @(posedge clk100) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk100) begin
    if (reset) begin
      state   <= rx_idle;
      timer   <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        rx_idle: begin
          if (rx_prev && !rx_sync) begin // falling edge
            timer <= tw'(quarter - 1);
            state <= rx_verify_start;
          end
        end
        rx_verify_start: begin
          if (rx_sync) begin
            state <= rx_idle;        // glitch, no output
          end else if (timer == '0) begin
            timer <= tw'(to_mid);
            state <= rx_mid_start;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        rx_mid_start: begin
          if (timer == '0) begin
            timer   <= tw'(clks_per_bit - 1);
            bit_cnt <= '0;
            state   <= rx_sync ? rx_done : rx_data_bits; // lost start still reported
          end else begin
            timer <= timer - 1'b1;
          end
        end
        rx_data_bits: begin
          if (timer == '0) begin
            timer   <= tw'(clks_per_bit - 1);
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= rx_stop_bit;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        rx_stop_bit: begin
          if (timer == '0) state <= rx_done;
          else timer <= timer - 1'b1;
        end
        rx_done: state <= rx_idle;
        default: state <= rx_idle;
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk100) begin
    if (state == rx_mid_start && timer == '0) begin
      word_q.start_err <= rx_sync;
      word_q.frame_err <= 1'b0;
      word_q.data      <= '0;
    end
    if (state == rx_data_bits && timer == '0) begin
      shift <= {rx_sync, shift[7:1]}; // lsb arrives first
    end
    if (state == rx_stop_bit && timer == '0) begin
      word_q.data      <= shift;
      word_q.frame_err <= !rx_sync;
    end
  end

  assign out.valid = (state == rx_done); // one cycle per frame
  assign out.word  = word_q;

endmodule

`default_nettype wire

// ==== rtl/char_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface char_if;
  import uart_pkg::*;

  logic     valid;
  logic     ready;
  rx_word_t word;

  // producer side
  modport source (
    output valid,
    output word,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  word,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // receiver FSM
  typedef enum logic [2:0] {
    rx_idle         = 3'd0,
    rx_verify_start = 3'd1,
    rx_mid_start    = 3'd2,
    rx_data_bits    = 3'd3,
    rx_stop_bit     = 3'd4,
    rx_done         = 3'd5
  } rx_state_t;

  // transmitter FSM
  typedef enum logic [1:0] {
    tx_idle  = 2'd0,
    tx_start = 2'd1,
    tx_data  = 2'd2,
    tx_stop  = 2'd3
  } tx_state_t;

  // wishbone register map, one address bit
  typedef enum logic {
    reg_data   = 1'b0,
    reg_status = 1'b1
  } reg_addr_t;

  // one received character plus its flags
  typedef struct packed {
    logic       start_err; // start bit high at midpoint
    logic       frame_err; // stop bit sampled low
    logic [7:0] data;
  } rx_word_t;

endpackage

`default_nettype wire
